// ==== verilog/mem_pkg.sv ====
// memory stage shared definitions
// data word and register index types, the load/store size encoding
// and the data RAM geometry and access wait
package mem_pkg;

    // 32-bit data or address word
    typedef logic [31:0] word_t;

    // general register index, x0 reads as zero
    typedef logic [4:0] reg_idx_t;

    // index into the small set of forwarded CSRs
    typedef logic [1:0] csr_idx_t;

    // encodings follow the RV32 load/store funct3 field
    typedef enum logic [2:0] {
        SZ_BYTE   = 3'b000,
        SZ_HALF   = 3'b001,
        SZ_WORD   = 3'b010,
        SZ_BYTE_U = 3'b100,
        SZ_HALF_U = 3'b101
    } mem_size_e;

    // data RAM depth in words, must be a power of two
    localparam int DMEM_WORDS = 256;

    // word index width into the RAM
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // edges from the first sample of an access to its completion pulse
    localparam int MEM_WAIT_CYCLES = 2;

    // wait counter has to hold the value MEM_WAIT_CYCLES itself
    localparam int WAIT_CNT_W = $clog2(MEM_WAIT_CYCLES + 1);

endpackage

// ==== verilog/dmem_if.sv ====
// data memory access bus
// the stage top issues a held request (re or we with addr, wdata and size),
// the data RAM answers with a one-cycle rvalid or wready pulse
`timescale 1ns/1ps

interface dmem_if;
    import mem_pkg::*;

    word_t     addr;
    word_t     wdata;
    logic      re;
    logic      we;
    mem_size_e size;

    word_t     rdata;
    logic      rvalid;
    logic      wready;

    modport master (output addr, wdata, re, we, size, input rdata, rvalid, wready);

    modport slave (input addr, wdata, re, we, size, output rdata, rvalid, wready);

    // forwarding unit only watches the request state and the load data
    modport monitor (input re, we, rvalid, wready, rdata);

endinterface

// ==== verilog/data_mem.sv ====
// data memory
// byte-addressed word RAM with a fixed wait before every access completes
// stores write a byte, halfword or word lane, loads return the lane
// sign or zero extended, registered together with the rvalid pulse
`timescale 1ns/1ps

module data_mem (
    input  logic   clk,
    input  logic   rst_n,
    dmem_if.slave  bus
);
    import mem_pkg::*;

    word_t                  ram [DMEM_WORDS];

    logic [WAIT_CNT_W-1:0]  wait_cnt;
    logic                   rvalid_q;
    logic                   wready_q;
    word_t                  rdata_q;

    logic [DMEM_IDX_W-1:0]  word_idx;
    logic                   busy;
    logic                   done;
    logic                   wait_over;

    logic [3:0]             byte_en;
    word_t                  wdata_lane;
    word_t                  rword;
    logic [7:0]             rbyte;
    logic [15:0]            rhalf;
    word_t                  load_val;

    // address wraps modulo the RAM depth
    assign word_idx  = bus.addr[DMEM_IDX_W+1:2];

    assign busy      = bus.re || bus.we;
    assign done      = rvalid_q || wready_q;
    assign wait_over = (wait_cnt == WAIT_CNT_W'(MEM_WAIT_CYCLES));

    // store lane select, data replicated so every enabled lane sees it
    always_comb begin
        case (bus.size)
            SZ_BYTE, SZ_BYTE_U: begin
                byte_en    = 4'b0001 << bus.addr[1:0];
                wdata_lane = {4{bus.wdata[7:0]}};
            end
            SZ_HALF, SZ_HALF_U: begin
                byte_en    = bus.addr[1] ? 4'b1100 : 4'b0011;
                wdata_lane = {2{bus.wdata[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                wdata_lane = bus.wdata;
            end
        endcase
    end

    // load lane select and extension
    always_comb begin
        rword = ram[word_idx];
        rbyte = rword[8*bus.addr[1:0] +: 8];
        rhalf = bus.addr[1] ? rword[31:16] : rword[15:0];
        case (bus.size)
            SZ_BYTE:   load_val = {{24{rbyte[7]}}, rbyte};
            SZ_BYTE_U: load_val = {24'b0, rbyte};
            SZ_HALF:   load_val = {{16{rhalf[15]}}, rhalf};
            SZ_HALF_U: load_val = {16'b0, rhalf};
            default:   load_val = rword;
        endcase
    end

    // wait counter counts sampled edges, the completion pulse lands
    // MEM_WAIT_CYCLES edges after the first one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            rvalid_q <= 1'b0;
            wready_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= 1'b0;
            wready_q <= 1'b0;
            if (done || !busy) begin
                // a request still high after the pulse is sampled afresh
                wait_cnt <= '0;
            end else if (wait_over) begin
                wait_cnt <= '0;
                rvalid_q <= bus.re;
                wready_q <= bus.we;
                if (bus.re) begin
                    rdata_q <= load_val;
                end
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // store lands at the edge that closes the wready cycle
    always_ff @(posedge clk) begin
        if (wready_q && bus.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    ram[word_idx][8*lane +: 8] <= wdata_lane[8*lane +: 8];
                end
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.wready = wready_q;
    assign bus.rdata  = rdata_q;

endmodule

// ==== verilog/forward_unit.sv ====
// operand forwarding and hazard unit
// feeds the execute stage rs1, rs2 and the CSR source from the instruction
// in memory or in write-back, memory first, and holds the front of the
// pipeline while a data memory access is outstanding
`timescale 1ns/1ps

module forward_unit (
    dmem_if.monitor             bus,

    input  mem_pkg::reg_idx_t   ex_rs1,
    input  mem_pkg::reg_idx_t   ex_rs2,
    input  mem_pkg::csr_idx_t   ex_csr_rs,

    input  mem_pkg::reg_idx_t   mem_rd,
    input  mem_pkg::csr_idx_t   mem_csr_rd,
    input  logic                mem_write_gpr,
    input  logic                mem_write_csr,
    input  logic                mem_to_reg,
    input  mem_pkg::word_t      mem_alu_out,
    input  mem_pkg::word_t      mem_csr_out,

    input  mem_pkg::reg_idx_t   wb_rd,
    input  mem_pkg::csr_idx_t   wb_csr_rd,
    input  logic                wb_write_gpr,
    input  logic                wb_write_csr,
    input  mem_pkg::word_t      wb_gpr_data,
    input  mem_pkg::word_t      wb_csr_data,

    output mem_pkg::word_t      rs1_data,
    output mem_pkg::word_t      rs2_data,
    output mem_pkg::word_t      csr_rs_data,
    output logic                rs1_hazard,
    output logic                rs2_hazard,
    output logic                csr_rs_hazard,

    output logic                stall_if,
    output logic                stall_id,
    output logic                stall_me,
    output logic                flush_wb
);
    import mem_pkg::*;

    word_t mem_gpr_val;
    logic  pending;

    logic  rs1_mem_hit;
    logic  rs1_wb_hit;
    logic  rs2_mem_hit;
    logic  rs2_wb_hit;
    logic  csr_mem_hit;
    logic  csr_wb_hit;

    // x0 never forwards
    function automatic logic gpr_hit(input logic wr, input reg_idx_t rd, input reg_idx_t src);
        return wr && (rd == src) && (src != '0);
    endfunction

    // every CSR index is a real register, zero included
    function automatic logic csr_hit(input logic wr, input csr_idx_t rd, input csr_idx_t src);
        return wr && (rd == src);
    endfunction

    // a load in memory forwards the RAM data, anything else its ALU result
    assign mem_gpr_val = mem_to_reg ? bus.rdata : mem_alu_out;

    assign rs1_mem_hit = gpr_hit(mem_write_gpr, mem_rd, ex_rs1);
    assign rs1_wb_hit  = gpr_hit(wb_write_gpr, wb_rd, ex_rs1);
    assign rs2_mem_hit = gpr_hit(mem_write_gpr, mem_rd, ex_rs2);
    assign rs2_wb_hit  = gpr_hit(wb_write_gpr, wb_rd, ex_rs2);
    assign csr_mem_hit = csr_hit(mem_write_csr, mem_csr_rd, ex_csr_rs);
    assign csr_wb_hit  = csr_hit(wb_write_csr, wb_csr_rd, ex_csr_rs);

    always_comb begin
        if (rs1_mem_hit) begin
            rs1_data = mem_gpr_val;
        end else if (rs1_wb_hit) begin
            rs1_data = wb_gpr_data;
        end else begin
            rs1_data = '0;
        end
    end

    always_comb begin
        if (rs2_mem_hit) begin
            rs2_data = mem_gpr_val;
        end else if (rs2_wb_hit) begin
            rs2_data = wb_gpr_data;
        end else begin
            rs2_data = '0;
        end
    end

    always_comb begin
        if (csr_mem_hit) begin
            csr_rs_data = mem_csr_out;
        end else if (csr_wb_hit) begin
            csr_rs_data = wb_csr_data;
        end else begin
            csr_rs_data = '0;
        end
    end

    assign rs1_hazard    = rs1_mem_hit || rs1_wb_hit;
    assign rs2_hazard    = rs2_mem_hit || rs2_wb_hit;
    assign csr_rs_hazard = csr_mem_hit || csr_wb_hit;

    // request up but no completion pulse yet
    assign pending = (bus.re || bus.we) && !(bus.rvalid || bus.wready);

    // fetch, decode and memory hold, write-back gets a bubble
    assign stall_if = pending;
    assign stall_id = pending;
    assign stall_me = pending;
    assign flush_wb = pending;

endmodule

// ==== verilog/mem_stage_top.sv ====
// memory stage of the RV32 pipeline
// issues the data memory request from the stage inputs, forwards operands
// to execute and passes the write-back controls straight through
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                clk,
    input  logic                rst_n,

    input  mem_pkg::word_t      pc,
    input  mem_pkg::word_t      inst,
    input  mem_pkg::word_t      alu_out,
    input  mem_pkg::word_t      csr_out,
    input  mem_pkg::reg_idx_t   rd,
    input  mem_pkg::csr_idx_t   csr_rd,
    input  mem_pkg::word_t      rs2_data,
    input  mem_pkg::mem_size_e  mem_size,
    input  logic                write_gpr,
    input  logic                write_csr,
    input  logic                mem_to_reg,
    input  logic                write_mem,
    input  logic                commit,
    input  logic                halt,
    input  logic                op_valid,

    input  mem_pkg::reg_idx_t   ex_rs1,
    input  mem_pkg::reg_idx_t   ex_rs2,
    input  mem_pkg::csr_idx_t   ex_csr_rs,

    input  mem_pkg::reg_idx_t   wb_rd,
    input  mem_pkg::csr_idx_t   wb_csr_rd,
    input  logic                wb_write_gpr,
    input  logic                wb_write_csr,
    input  mem_pkg::word_t      wb_gpr_data,
    input  mem_pkg::word_t      wb_csr_data,

    output mem_pkg::word_t      pc_wb,
    output mem_pkg::word_t      inst_wb,
    output mem_pkg::word_t      alu_out_wb,
    output mem_pkg::word_t      csr_out_wb,
    output mem_pkg::reg_idx_t   rd_wb,
    output mem_pkg::csr_idx_t   csr_rd_wb,
    output logic                write_gpr_wb,
    output logic                write_csr_wb,
    output logic                mem_to_reg_wb,
    output logic                commit_wb,
    output logic                halt_wb,
    output logic                op_valid_wb,
    output mem_pkg::word_t      mem_rdata,

    output mem_pkg::word_t      fwd_rs1_data,
    output mem_pkg::word_t      fwd_rs2_data,
    output mem_pkg::word_t      fwd_csr_rs_data,
    output logic                rs1_hazard,
    output logic                rs2_hazard,
    output logic                csr_rs_hazard,
    output logic                stall_if,
    output logic                stall_id,
    output logic                stall_me,
    output logic                flush_wb
);

    dmem_if dmem_bus ();

    // loads and stores share the ALU result as address
    assign dmem_bus.addr  = alu_out;
    assign dmem_bus.wdata = rs2_data;
    assign dmem_bus.re    = mem_to_reg;
    assign dmem_bus.we    = write_mem;
    assign dmem_bus.size  = mem_size;

    assign mem_rdata     = dmem_bus.rdata;

    assign pc_wb         = pc;
    assign inst_wb       = inst;
    assign alu_out_wb    = alu_out;
    assign csr_out_wb    = csr_out;
    assign rd_wb         = rd;
    assign csr_rd_wb     = csr_rd;
    assign write_gpr_wb  = write_gpr;
    assign write_csr_wb  = write_csr;
    assign mem_to_reg_wb = mem_to_reg;
    assign commit_wb     = commit;
    assign halt_wb       = halt;
    assign op_valid_wb   = op_valid;

    data_mem data_mem_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (dmem_bus)
    );

    forward_unit forward_unit_inst (
        .bus           (dmem_bus),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_csr_rs     (ex_csr_rs),
        .mem_rd        (rd),
        .mem_csr_rd    (csr_rd),
        .mem_write_gpr (write_gpr),
        .mem_write_csr (write_csr),
        .mem_to_reg    (mem_to_reg),
        .mem_alu_out   (alu_out),
        .mem_csr_out   (csr_out),
        .wb_rd         (wb_rd),
        .wb_csr_rd     (wb_csr_rd),
        .wb_write_gpr  (wb_write_gpr),
        .wb_write_csr  (wb_write_csr),
        .wb_gpr_data   (wb_gpr_data),
        .wb_csr_data   (wb_csr_data),
        .rs1_data      (fwd_rs1_data),
        .rs2_data      (fwd_rs2_data),
        .csr_rs_data   (fwd_csr_rs_data),
        .rs1_hazard    (rs1_hazard),
        .rs2_hazard    (rs2_hazard),
        .csr_rs_hazard (csr_rs_hazard),
        .stall_if      (stall_if),
        .stall_id      (stall_id),
        .stall_me      (stall_me),
        .flush_wb      (flush_wb)
    );

endmodule

// ==== tests/mem_stage_properties.sv ====
// memory stage assertions
// completion pulse shape, stall release and x0 forwarding
`timescale 1ns/1ps

module mem_stage_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              rvalid,
    input logic              wready,
    input logic              re,
    input logic              we,
    input logic              stall_if,
    input logic              stall_id,
    input logic              stall_me,
    input logic              flush_wb,
    input mem_pkg::reg_idx_t ex_rs1,
    input mem_pkg::reg_idx_t ex_rs2,
    input logic              rs1_hazard,
    input logic              rs2_hazard
);
    import mem_pkg::*;

    a_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid || wready) |=> !(rvalid || wready))
        else $error("completion pulse held longer than one cycle");

    // load data only answers a held read and never a lone write
    a_rvalid_from_load: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> $past(re, MEM_WAIT_CYCLES) && !$past(we))
        else $error("rvalid without a pending load");

    // the stall group only lets go through a completion pulse
    a_stall_release: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_if || stall_id || stall_me || flush_wb) |=> (stall_me || rvalid || wready))
        else $error("stall released without a completion pulse");

    a_no_x0_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        !((ex_rs1 == '0) && rs1_hazard) && !((ex_rs2 == '0) && rs2_hazard))
        else $error("hazard flagged on register x0");

endmodule

bind mem_stage_top mem_stage_properties mem_stage_properties_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rvalid     (dmem_bus.rvalid),
    .wready     (dmem_bus.wready),
    .re         (mem_to_reg),
    .we         (write_mem),
    .stall_if   (stall_if),
    .stall_id   (stall_id),
    .stall_me   (stall_me),
    .flush_wb   (flush_wb),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2),
    .rs1_hazard (rs1_hazard),
    .rs2_hazard (rs2_hazard)
);

// ==== tests/mem_stage_tb.sv ====
// memory stage testbench
// plays the fetch, decode, execute and write-back stages around the memory
// stage and checks data memory access, stall timing, operand forwarding
// and the write-back pass-through
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    logic       clk;
    logic       rst_n;
    word_t      pc, inst, alu_out, csr_out, rs2_data, wb_gpr_data, wb_csr_data;
    reg_idx_t   rd, ex_rs1, ex_rs2, wb_rd;
    csr_idx_t   csr_rd, ex_csr_rs, wb_csr_rd;
    mem_size_e  mem_size;
    logic       write_gpr, write_csr, mem_to_reg, write_mem, commit, halt, op_valid;
    logic       wb_write_gpr, wb_write_csr;

    word_t      pc_wb, inst_wb, alu_out_wb, csr_out_wb, mem_rdata;
    reg_idx_t   rd_wb;
    csr_idx_t   csr_rd_wb;
    logic       write_gpr_wb, write_csr_wb, mem_to_reg_wb, commit_wb, halt_wb, op_valid_wb;
    word_t      fwd_rs1_data, fwd_rs2_data, fwd_csr_rs_data;
    logic       rs1_hazard, rs2_hazard, csr_rs_hazard;
    logic       stall_if, stall_id, stall_me, flush_wb;

    // byte image of the data RAM as the stores should have left it
    logic [7:0] model [DMEM_WORDS*4];
    word_t      lfsr_state;
    word_t      last_rdata;
    word_t      last_fwd_rs2;
    int         last_cycles;
    logic       stall_agree;
    int         errors;
    int         checks;
    int         tests;
    int         test_errors;

    mem_stage_top mem_stage_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            test_errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            test_errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // byte offset of the addressed word with the RAM index wrapping at its depth
    function automatic int model_base(input word_t addr);
        return int'((addr >> 2) % DMEM_WORDS) * 4;
    endfunction

    function automatic word_t expect_load(input word_t addr, input mem_size_e size);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        base = model_base(addr);
        b = model[base + int'(addr[1:0])];
        h = {model[base + 2 * int'(addr[1]) + 1], model[base + 2 * int'(addr[1])]};
        case (size)
            SZ_BYTE:   return {{24{b[7]}}, b};
            SZ_BYTE_U: return {24'h0, b};
            SZ_HALF:   return {{16{h[15]}}, h};
            SZ_HALF_U: return {16'h0, h};
            default:   return {model[base + 3], model[base + 2], model[base + 1], model[base]};
        endcase
    endfunction

    // issue one access, hold it until the completion cycle, then release it
    task automatic mem_access(input logic is_load, input word_t addr, input word_t data,
                              input mem_size_e size);
        @(negedge clk);
        alu_out = addr;
        rs2_data = data;
        mem_size = size;
        mem_to_reg = is_load;
        write_mem = !is_load;
        last_cycles = 0;
        stall_agree = 1'b1;
        @(negedge clk);
        while (stall_me !== 1'b0 && last_cycles < TIMEOUT_CYCLES) begin
            stall_agree &= (stall_if === 1'b1) && (stall_id === 1'b1) && (flush_wb === 1'b1);
            last_cycles++;
            @(negedge clk);
        end
        if (last_cycles >= TIMEOUT_CYCLES) begin
            $display("data memory access at %h never completed", addr);
            $display(">>> FAIL");
            $finish;
        end else begin
            stall_agree &= !(stall_if || stall_id || flush_wb);
            last_rdata = mem_rdata;
            last_fwd_rs2 = fwd_rs2_data;
            check_flag("mem_to_reg pass", is_load, mem_to_reg_wb);
            mem_to_reg = 1'b0;
            // store lands at the edge closing its wready cycle
            if (!is_load) @(negedge clk);
            write_mem = 1'b0;
        end
    endtask

    task automatic store_data(input word_t addr, input word_t data, input mem_size_e size);
        int base;
        base = model_base(addr);
        mem_access(1'b0, addr, data, size);
        case (size)
            SZ_BYTE, SZ_BYTE_U: model[base + int'(addr[1:0])] = data[7:0];
            SZ_HALF, SZ_HALF_U: begin
                model[base + 2 * int'(addr[1])] = data[7:0];
                model[base + 2 * int'(addr[1]) + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) model[base + i] = data[8*i +: 8];
            end
        endcase
    endtask

    task automatic load_and_check(input string name, input word_t addr, input mem_size_e size);
        mem_access(1'b1, addr, 32'h0, size);
        check_word(name, expect_load(addr, size), last_rdata);
    endtask

    task automatic load_all_sizes(input string name, input word_t base);
        mem_size_e sizes [5] = '{SZ_BYTE, SZ_HALF, SZ_WORD, SZ_BYTE_U, SZ_HALF_U};
        for (int lane = 0; lane < 4; lane++) begin
            foreach (sizes[s]) begin
                load_and_check(name, base + word_t'(lane), sizes[s]);
            end
        end
    endtask

    task automatic check_passthrough();
        #1;
        check_word("pc pass", pc, pc_wb);
        check_word("inst pass", inst, inst_wb);
        check_word("alu pass", alu_out, alu_out_wb);
        check_word("csr pass", csr_out, csr_out_wb);
        check_word("rd pass", word_t'(rd), word_t'(rd_wb));
        check_word("csr_rd pass", word_t'(csr_rd), word_t'(csr_rd_wb));
        check_flag("control pass", 1'b1,
                   {write_gpr, write_csr, mem_to_reg, commit, halt, op_valid} ===
                   {write_gpr_wb, write_csr_wb, mem_to_reg_wb, commit_wb, halt_wb, op_valid_wb});
    endtask

    task automatic word_roundtrip();
        store_data(32'h0000_0040, 32'hdead_beef, SZ_WORD);
        load_and_check("word reload", 32'h0000_0040, SZ_WORD);
        check_word("word literal", 32'hdead_beef, last_rdata);
        finish_test("word store then load");
    endtask

    task automatic narrow_access();
        store_data(32'h0000_0100, 32'h0, SZ_WORD);
        for (int lane = 0; lane < 4; lane++) begin
            store_data(32'h0000_0100 + word_t'(lane), 32'h80 + word_t'(49 * lane), SZ_BYTE);
        end
        load_all_sizes("byte lanes", 32'h0000_0100);
        store_data(32'h0000_0100, 32'h0000_8001, SZ_HALF);
        store_data(32'h0000_0102, 32'h0000_7ffe, SZ_HALF);
        load_all_sizes("half lanes", 32'h0000_0100);
        finish_test("narrow accesses");
    endtask

    task automatic stall_timing();
        @(negedge clk);
        check_flag("idle stall", 1'b0, stall_if || stall_id || stall_me || flush_wb);
        mem_access(1'b1, 32'h0000_0040, 32'h0, SZ_WORD);
        check_word("load stall cycles", word_t'(MEM_WAIT_CYCLES), word_t'(last_cycles));
        check_flag("load stall group", 1'b1, stall_agree);
        store_data(32'h0000_0044, 32'h0bad_cafe, SZ_WORD);
        check_word("store stall cycles", word_t'(MEM_WAIT_CYCLES), word_t'(last_cycles));
        check_flag("store stall group", 1'b1, stall_agree);
        finish_test("stall timing");
    endtask

    task automatic forwarding_priority();
        @(negedge clk);
        {rd, wb_rd, ex_rs1} = {5'd9, 5'd9, 5'd9};
        {csr_rd, wb_csr_rd, ex_csr_rs} = {2'd2, 2'd2, 2'd2};
        {write_gpr, wb_write_gpr, write_csr, wb_write_csr} = 4'b1111;
        alu_out = 32'h1111_0009;
        wb_gpr_data = 32'h2222_0009;
        csr_out = 32'h3333_0002;
        wb_csr_data = 32'h4444_0002;
        #1;
        check_word("rs1 from memory", 32'h1111_0009, fwd_rs1_data);
        check_flag("rs1 hazard", 1'b1, rs1_hazard);
        check_word("csr from memory", 32'h3333_0002, fwd_csr_rs_data);
        @(negedge clk);
        {write_gpr, write_csr} = 2'b00;
        #1;
        check_word("rs1 from write-back", 32'h2222_0009, fwd_rs1_data);
        check_word("csr from write-back", 32'h4444_0002, fwd_csr_rs_data);
        @(negedge clk);
        {rd, wb_rd, ex_rs1, csr_rd, ex_csr_rs} = 19'h0;
        {write_gpr, write_csr} = 2'b11;
        #1;
        check_flag("rs1 hazard on x0", 1'b0, rs1_hazard);
        check_flag("csr hazard on index 0", 1'b1, csr_rs_hazard);
        check_word("csr index 0", 32'h3333_0002, fwd_csr_rs_data);
        @(negedge clk);
        {write_gpr, write_csr, wb_write_gpr, wb_write_csr} = 4'b0000;
        finish_test("forwarding priority");
    endtask

    task automatic load_forwarding();
        store_data(32'h0000_0200, 32'hc0de_1234, SZ_WORD);
        @(negedge clk);
        rd = 5'd7;
        ex_rs2 = 5'd7;
        write_gpr = 1'b1;
        mem_access(1'b1, 32'h0000_0200, 32'h0, SZ_WORD);
        check_word("rs2 from load", 32'hc0de_1234, last_fwd_rs2);
        check_flag("rs2 hazard", 1'b1, rs2_hazard);
        write_gpr = 1'b0;
        ex_rs2 = '0;
        finish_test("load forwarding");
    endtask

    task automatic random_traffic();
        mem_size_e sizes [5] = '{SZ_BYTE, SZ_HALF, SZ_WORD, SZ_BYTE_U, SZ_HALF_U};
        mem_size_e size;
        word_t     addr;
        word_t     data;
        for (int n = 0; n < 64; n++) begin
            addr = rand_bits(32);
            data = rand_bits(32);
            size = sizes[rand_bits(3) % 5];
            if (size == SZ_HALF || size == SZ_HALF_U) addr[0] = 1'b0;
            if (size == SZ_WORD) addr[1:0] = 2'b00;
            pc = rand_bits(32);
            inst = rand_bits(32);
            csr_out = rand_bits(32);
            rd = reg_idx_t'(rand_bits(5));
            csr_rd = csr_idx_t'(rand_bits(2));
            {write_gpr, write_csr, commit, halt, op_valid} = 5'(rand_bits(5));
            store_data(addr, data, size);
            check_passthrough();
            load_and_check("random reload", addr, size);
            check_passthrough();
        end
        finish_test("random traffic");
    endtask

    initial begin
        lfsr_state = 32'h7818_268a;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        rst_n = 1'b0;
        {pc, inst, alu_out, csr_out, rs2_data, wb_gpr_data, wb_csr_data} = 224'h0;
        {rd, ex_rs1, ex_rs2, wb_rd, csr_rd, ex_csr_rs, wb_csr_rd} = 26'h0;
        {write_gpr, write_csr, mem_to_reg, write_mem, commit, halt, op_valid} = 7'h0;
        {wb_write_gpr, wb_write_csr} = 2'b00;
        mem_size = SZ_WORD;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        word_roundtrip();
        narrow_access();
        stall_timing();
        forwarding_priority();
        load_forwarding();
        random_traffic();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/mem_pkg.sv
verilog/dmem_if.sv
verilog/data_mem.sv
verilog/forward_unit.sv
verilog/mem_stage_top.sv
tests/mem_stage_properties.sv
tests/mem_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory stage testbench

TOP := mem_stage_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
